// ==== sap_settings.svh ====
`ifndef SAP_SETTINGS_SVH
`define SAP_SETTINGS_SVH

// widths shared by every block of the machine

`define SAP_WORD_WIDTH 8  // bus, registers, ram words

`define SAP_ADDR_WIDTH 4  // pc and mar width

`define SAP_RAM_DEPTH 16  // bytes of ram

`define SAP_NUM_STEPS 5   // microsteps per instruction, T0..T4

`endif

// ==== sap_data_pkg.sv ====
`include "sap_settings.svh"

package sap_data_pkg;

    // one bus or register value
    typedef logic [`SAP_WORD_WIDTH-1:0] word_t;

    // one ram address, also the pc value
    typedef logic [`SAP_ADDR_WIDTH-1:0] addr_t;

    // stored alu condition flags
    typedef struct packed {
        logic carry;  // carry out of the last add/sub
        logic zero;   // last result was all zero
    } flags_t;

    // which block currently owns the shared bus
    typedef enum logic [2:0] {
        SRC_NONE = 3'd0,  // bus idles at zero
        SRC_PC   = 3'd1,  // program counter, zero extended
        SRC_RAM  = 3'd2,  // ram word at mar
        SRC_IR   = 3'd3,  // operand nibble, zero extended
        SRC_A    = 3'd4,  // accumulator
        SRC_ALU  = 3'd5   // alu sum
    } bus_src_e;

endpackage

// ==== sap_ctrl_pkg.sv ====
`include "sap_settings.svh"

package sap_ctrl_pkg;

    // upper nibble of an instruction
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LDA = 4'd1,   // a <= ram[operand]
        OP_ADD = 4'd2,   // a <= a + ram[operand]
        OP_SUB = 4'd3,   // a <= a - ram[operand]
        OP_STA = 4'd4,   // ram[operand] <= a
        OP_LDI = 4'd5,   // a <= operand
        OP_JMP = 4'd6,
        OP_JC  = 4'd7,   // jump if carry set
        OP_JZ  = 4'd8,   // jump if zero set
        OP_CLF = 4'd9,   // clear both flags
        OP_OUT = 4'd14,  // out register <= a
        OP_HLT = 4'd15
    } opcode_e;

    // microstep within one instruction
    typedef enum logic [$clog2(`SAP_NUM_STEPS)-1:0] {
        T0 = 'd0,  // pc to mar
        T1 = 'd1,  // ram to ir, pc + 1
        T2 = 'd2,
        T3 = 'd3,
        T4 = 'd4
    } step_e;

    // all strobes from the sequencer, one bit each
    typedef struct packed {
        logic pc_oe;      // bus output enables, one hot or none
        logic ram_oe;
        logic ir_oe;
        logic a_oe;
        logic alu_oe;
        logic mar_load;   // load strobes
        logic ram_we;
        logic ir_load;
        logic a_load;
        logic b_load;
        logic out_load;
        logic pc_load;
        logic pc_inc;     // remaining strobes
        logic subtract;
        logic flag_load;
        logic flag_clr;
        logic halt;
    } ctrl_word_t;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ps

`include "sap_settings.svh"

module alu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sap_ctrl_pkg::ctrl_word_t ctrl,
    input  sap_data_pkg::word_t      a,
    input  sap_data_pkg::word_t      b,
    output sap_data_pkg::word_t      result,
    output sap_data_pkg::flags_t     flags
);

    import sap_data_pkg::*;

    word_t                   b_eff;    // b or its complement
    logic [`SAP_WORD_WIDTH:0] sum_ext; // sum with carry bit on top
    word_t                   sum;
    flags_t                  flag_d;   // next flag value

    // two's complement subtract: invert b, carry in of one
    assign b_eff   = ctrl.subtract ? ~b : b;
    assign sum_ext = {1'b0, a} + {1'b0, b_eff} + {{`SAP_WORD_WIDTH{1'b0}}, ctrl.subtract};
    assign sum     = sum_ext[`SAP_WORD_WIDTH-1:0];

    assign flag_d.carry = sum_ext[`SAP_WORD_WIDTH]; // for sub, set when a >= b
    assign flag_d.zero  = (sum == '0);               // whole word zero

    // result only while the alu owns the bus
    assign result = ctrl.alu_oe ? sum : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ctrl.flag_clr) begin // clear wins over load
            flags <= '0;
        end else if (ctrl.flag_load) begin
            flags <= flag_d;
        end
    end

endmodule

// ==== program_counter.sv ====
`timescale 1ns/1ps

`include "sap_settings.svh"

module program_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  sap_ctrl_pkg::ctrl_word_t ctrl,
    input  sap_data_pkg::word_t      bus,
    output sap_data_pkg::addr_t      pc
);

    import sap_data_pkg::*;

    addr_t jump_target;  // low nibble of the bus

    assign jump_target = bus[`SAP_ADDR_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;              // next run starts at address 0
        end else if (ctrl.pc_load) begin
            pc <= jump_target;     // jumps take priority
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;       // wraps at 16
        end
    end

endmodule

// ==== memory_unit.sv ====
`timescale 1ns/1ps

`include "sap_settings.svh"

module memory_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  sap_ctrl_pkg::ctrl_word_t ctrl,
    input  sap_data_pkg::word_t      bus,
    input  logic                     prog_we,
    input  sap_data_pkg::addr_t      prog_addr,
    input  sap_data_pkg::word_t      prog_data,
    output sap_data_pkg::word_t      ram_data
);

    import sap_data_pkg::*;

    addr_t mar;                        // memory address register
    word_t ram [`SAP_RAM_DEPTH];       // program and data store
    logic  cpu_we;                     // write from the bus
    logic  load_we;                    // write from the load port

    assign cpu_we  = run && ctrl.ram_we;
    assign load_we = !run && prog_we;  // loader only while stopped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (!run) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= bus[`SAP_ADDR_WIDTH-1:0]; // address from low nibble
        end
    end

    // ram writes from the bus or the loader
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            ram[mar] <= bus;               // STA path
        end else if (load_we) begin
            ram[prog_addr] <= prog_data;   // testbench loader
        end
    end

    // asynchronous read at the mar
    assign ram_data = ram[mar];

endmodule

// ==== register_block.sv ====
`timescale 1ns/1ps

module register_block (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sap_ctrl_pkg::ctrl_word_t ctrl,
    input  sap_data_pkg::word_t      bus,
    output sap_data_pkg::word_t      a,
    output sap_data_pkg::word_t      b,
    output sap_data_pkg::word_t      out_data,
    output logic                     out_valid
);

    // accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a <= '0;
        end else if (ctrl.a_load) begin
            a <= bus;
        end
    end

    // second alu operand, only fed from ram
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b <= '0;
        end else if (ctrl.b_load) begin
            b <= bus;
        end
    end

    // output register takes a directly, not from the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_data  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= ctrl.out_load;   // one cycle pulse per OUT
            if (ctrl.out_load) begin
                out_data <= a;            // held until next OUT
            end
        end
    end

endmodule

// ==== sequencer.sv ====
`timescale 1ns/1ps

module sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  sap_data_pkg::word_t      bus,
    input  sap_data_pkg::flags_t     flags,
    output sap_data_pkg::addr_t      operand,
    output sap_ctrl_pkg::ctrl_word_t ctrl,
    output logic                     halted
);

    import sap_data_pkg::*;
    import sap_ctrl_pkg::*;

    word_t      ir;         // instruction register
    opcode_e    opcode;
    step_e      step;
    step_e      step_next;
    ctrl_word_t ctrl_raw;   // microcode before run/halt gating

    assign opcode  = opcode_e'(ir[7:4]);
    assign operand = ir[3:0];

    assign step_next = (step == T4) ? T0 : step_e'(step + 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= T0;
        end else if (!run) begin
            step <= T0;             // ready for a fresh start
        end else if (!halted) begin
            step <= step_next;      // frozen once halted
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (!run) begin
            ir <= '0;
        end else if (ctrl.ir_load) begin
            ir <= bus;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (!run) begin
            halted <= 1'b0;         // run low releases halt
        end else if (ctrl.halt) begin
            halted <= 1'b1;
        end
    end

    // microcode, one row per step
    always_comb begin
        ctrl_raw = '0;
        case (step)
            T0: begin
                ctrl_raw.pc_oe    = 1'b1;   // pc to mar
                ctrl_raw.mar_load = 1'b1;
            end
            T1: begin
                ctrl_raw.ram_oe  = 1'b1;    // fetch into ir
                ctrl_raw.ir_load = 1'b1;
                ctrl_raw.pc_inc  = 1'b1;
            end
            T2: begin
                case (opcode)
                    OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                        ctrl_raw.ir_oe    = 1'b1;  // operand to mar
                        ctrl_raw.mar_load = 1'b1;
                    end
                    OP_LDI: begin
                        ctrl_raw.ir_oe  = 1'b1;    // immediate nibble into a
                        ctrl_raw.a_load = 1'b1;
                    end
                    OP_JMP: begin
                        ctrl_raw.ir_oe   = 1'b1;
                        ctrl_raw.pc_load = 1'b1;
                    end
                    OP_JC: begin
                        ctrl_raw.ir_oe   = flags.carry; // taken only on carry
                        ctrl_raw.pc_load = flags.carry;
                    end
                    OP_JZ: begin
                        ctrl_raw.ir_oe   = flags.zero;
                        ctrl_raw.pc_load = flags.zero;
                    end
                    OP_CLF:  ctrl_raw.flag_clr = 1'b1;
                    OP_OUT:  ctrl_raw.out_load = 1'b1;
                    OP_HLT:  ctrl_raw.halt     = 1'b1;
                    default: ctrl_raw = '0;        // NOP and unused codes
                endcase
            end
            T3: begin
                case (opcode)
                    OP_LDA: begin
                        ctrl_raw.ram_oe = 1'b1;
                        ctrl_raw.a_load = 1'b1;
                    end
                    OP_ADD, OP_SUB: begin
                        ctrl_raw.ram_oe = 1'b1;    // operand into b
                        ctrl_raw.b_load = 1'b1;
                    end
                    OP_STA: begin
                        ctrl_raw.a_oe   = 1'b1;
                        ctrl_raw.ram_we = 1'b1;
                    end
                    default: ctrl_raw = '0;
                endcase
            end
            T4: begin
                if (opcode == OP_ADD || opcode == OP_SUB) begin
                    ctrl_raw.alu_oe    = 1'b1;     // sum back into a
                    ctrl_raw.a_load    = 1'b1;
                    ctrl_raw.flag_load = 1'b1;
                    ctrl_raw.subtract  = (opcode == OP_SUB);
                end
            end
            default: ctrl_raw = '0;
        endcase
    end

    // all strobes quiet when stopped or halted
    assign ctrl = (run && !halted) ? ctrl_raw : '0;

endmodule

// ==== sap_cpu.sv ====
`timescale 1ns/1ps

module sap_cpu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  logic                prog_we,
    input  sap_data_pkg::addr_t prog_addr,
    input  sap_data_pkg::word_t prog_data,
    output sap_data_pkg::word_t out_data,
    output logic                out_valid,
    output logic                halted
);

    import sap_data_pkg::*;
    import sap_ctrl_pkg::*;

    ctrl_word_t ctrl;
    word_t      bus;        // the one shared bus
    bus_src_e   bus_src;
    addr_t      pc;
    addr_t      operand;    // ir low nibble
    word_t      ram_data;
    word_t      a;
    word_t      b;
    word_t      alu_result;
    flags_t     flags;

    // encode the active output enable
    always_comb begin
        if (ctrl.pc_oe)       bus_src = SRC_PC;
        else if (ctrl.ram_oe) bus_src = SRC_RAM;
        else if (ctrl.ir_oe)  bus_src = SRC_IR;
        else if (ctrl.a_oe)   bus_src = SRC_A;
        else if (ctrl.alu_oe) bus_src = SRC_ALU;
        else                  bus_src = SRC_NONE;
    end

    always_comb begin
        case (bus_src)
            SRC_PC:  bus = word_t'(pc);       // zero extended
            SRC_RAM: bus = ram_data;
            SRC_IR:  bus = word_t'(operand);  // zero extended
            SRC_A:   bus = a;
            SRC_ALU: bus = alu_result;
            default: bus = '0;                // idle bus reads zero
        endcase
    end

    alu u_alu (.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .a(a), .b(b),
        .result(alu_result), .flags(flags));

    program_counter u_pc (.clk(clk), .rst_n(rst_n), .run(run), .ctrl(ctrl),
        .bus(bus), .pc(pc));

    memory_unit u_mem (.clk(clk), .rst_n(rst_n), .run(run), .ctrl(ctrl),
        .bus(bus), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .ram_data(ram_data));

    register_block u_regs (.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .bus(bus),
        .a(a), .b(b), .out_data(out_data), .out_valid(out_valid));

    sequencer u_seq (.clk(clk), .rst_n(rst_n), .run(run), .bus(bus),
        .flags(flags), .operand(operand), .ctrl(ctrl), .halted(halted));

endmodule

// ==== tb_sap_cpu.sv ====
`timescale 1ns/1ps

`include "sap_settings.svh"

module tb_sap_cpu;

    import sap_data_pkg::*;
    import sap_ctrl_pkg::*;

    localparam int NUM_ROWS    = 11;
    localparam int MAX_OUTS    = 4;
    localparam int CLK_PERIOD  = 8;
    localparam int HOLD_CYCLES = 3 * `SAP_NUM_STEPS;  // quiet window after HLT
    localparam int WATCHDOG_NS = (NUM_ROWS * 16 * `SAP_NUM_STEPS + 100) * CLK_PERIOD;

    logic  clk;
    logic  rst_n;
    logic  run;
    logic  prog_we;
    addr_t prog_addr;
    word_t prog_data;
    word_t out_data;
    logic  out_valid;
    logic  halted;

    word_t image     [NUM_ROWS][`SAP_RAM_DEPTH];  // program image per row
    string row_name  [NUM_ROWS];
    int    exp_count [NUM_ROWS];                  // expected number of outputs
    word_t exp_val   [NUM_ROWS][MAX_OUTS];

    int pass_count;
    int fail_count;

    sap_cpu UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .prog_we  (prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .out_data (out_data),
        .out_valid(out_valid),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t: the CPU never halted", $time);
        $display("=== FAIL ===");
        $finish;
    end

    // opcode in the upper nibble, operand below
    function automatic word_t instr(input opcode_e op, input addr_t arg);
        return {op, arg};
    endfunction

    task automatic start_row(input int r, input string name);
        int i;
        row_name[r]  = name;
        exp_count[r] = 0;
        for (i = 0; i < `SAP_RAM_DEPTH; i++) begin
            image[r][i] = instr(OP_NOP, 4'd0);  // unused bytes are NOP
        end
        for (i = 0; i < MAX_OUTS; i++) begin
            exp_val[r][i] = '0;
        end
    endtask

    task automatic expect_out(input int r, input int value);
        exp_val[r][exp_count[r]] = word_t'(value & 8'hff);  // bus is mod 256
        exp_count[r]++;
    endtask

    // LDA 14, op 15 with data words x and y
    task automatic arith_image(input int r, input opcode_e op, input int x, input int y);
        image[r][0]  = instr(OP_LDA, 4'd14);
        image[r][1]  = instr(op, 4'd15);
        image[r][14] = word_t'(x);
        image[r][15] = word_t'(y);
    endtask

    // arithmetic, optional CLF, then a jump to marker 1 or fall through to marker 0
    task automatic branch_image(input int r, input opcode_e op, input opcode_e jop,
                                input logic with_clf, input int x, input int y);
        int base;
        base = with_clf ? 3 : 2;
        arith_image(r, op, x, y);
        if (with_clf) begin
            image[r][2] = instr(OP_CLF, 4'd0);
        end
        image[r][base]     = instr(jop, addr_t'(base + 4));
        image[r][base + 1] = instr(OP_LDI, 4'd0);   // not taken
        image[r][base + 2] = instr(OP_OUT, 4'd0);
        image[r][base + 3] = instr(OP_HLT, 4'd0);
        image[r][base + 4] = instr(OP_LDI, 4'd1);   // taken
        image[r][base + 5] = instr(OP_OUT, 4'd0);
        image[r][base + 6] = instr(OP_HLT, 4'd0);
    endtask

    task automatic fill_table();
        int x;
        int y;
        int acc;
        x = $urandom & 8'hff;
        y = $urandom & 8'hff;
        start_row(0, "add_rand");
        arith_image(0, OP_ADD, x, y);
        image[0][2] = instr(OP_OUT, 4'd0);
        image[0][3] = instr(OP_HLT, 4'd0);
        expect_out(0, x + y);
        x = $urandom & 8'hff;
        y = $urandom & 8'hff;
        start_row(1, "sub_rand");
        arith_image(1, OP_SUB, x, y);
        image[1][2] = instr(OP_OUT, 4'd0);
        image[1][3] = instr(OP_HLT, 4'd0);
        expect_out(1, x - y);
        start_row(2, "carry_add_set");
        branch_image(2, OP_ADD, OP_JC, 1'b0, 200, 100);
        expect_out(2, (200 + 100 > 255) ? 1 : 0);      // carry out of 8 bits
        start_row(3, "carry_add_clear");
        branch_image(3, OP_ADD, OP_JC, 1'b0, 100, 50);
        expect_out(3, (100 + 50 > 255) ? 1 : 0);
        start_row(4, "carry_sub_ge");
        branch_image(4, OP_SUB, OP_JC, 1'b0, 20, 7);
        expect_out(4, (20 >= 7) ? 1 : 0);               // no borrow sets carry
        start_row(5, "carry_sub_lt");
        branch_image(5, OP_SUB, OP_JC, 1'b0, 7, 20);
        expect_out(5, (7 >= 20) ? 1 : 0);
        start_row(6, "zero_equal");
        branch_image(6, OP_SUB, OP_JZ, 1'b0, 42, 42);
        expect_out(6, (((42 - 42) & 8'hff) == 0) ? 1 : 0);
        start_row(7, "zero_unequal");
        branch_image(7, OP_SUB, OP_JZ, 1'b0, 42, 41);
        expect_out(7, (((42 - 41) & 8'hff) == 0) ? 1 : 0);
        start_row(8, "zero_after_clf");
        branch_image(8, OP_SUB, OP_JZ, 1'b1, 42, 42);
        expect_out(8, 0);                               // flags cleared before JZ
        start_row(9, "store_load");
        image[9][0] = instr(OP_LDI, 4'd7);
        image[9][1] = instr(OP_STA, 4'd13);
        image[9][2] = instr(OP_LDI, 4'd0);              // overwrite a first
        image[9][3] = instr(OP_LDA, 4'd13);
        image[9][4] = instr(OP_OUT, 4'd0);
        image[9][5] = instr(OP_HLT, 4'd0);
        expect_out(9, 7);
        start_row(10, "count_loop");
        image[10][0]  = instr(OP_LDI, 4'd0);
        image[10][1]  = instr(OP_ADD, 4'd15);
        image[10][2]  = instr(OP_OUT, 4'd0);
        image[10][3]  = instr(OP_JC, 4'd5);             // leave once it wraps
        image[10][4]  = instr(OP_JMP, 4'd1);
        image[10][5]  = instr(OP_HLT, 4'd0);
        image[10][15] = 8'h40;                          // step constant
        acc = 0;
        while (acc <= 255) begin
            acc = acc + 'h40;
            expect_out(10, acc);                        // OUT comes before JC
        end
    endtask

    task automatic write_image(input int r);
        int i;
        for (i = 0; i < `SAP_RAM_DEPTH; i++) begin
            @(posedge clk);
            #1;
            prog_we   = 1'b1;
            prog_addr = addr_t'(i);
            prog_data = image[r][i];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic execute_row(input int r);
        word_t got [$];
        int    errors;
        int    extra;
        int    n;
        int    i;
        logic  done;
        errors = 0;
        extra  = 0;
        done   = 1'b0;
        write_image(r);
        run = 1'b1;                                     // starts at address 0
        while (!done) begin
            @(negedge clk);
            if (out_valid) begin
                got.push_back(out_data);
            end
            done = halted;
        end
        for (i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            if (out_valid) begin
                extra++;
            end
            assert (halted) else begin
                $display("halted dropped at %0t in %s while run was high", $time, row_name[r]);
                errors++;
            end
        end
        assert (extra == 0) else begin
            $display("out_valid pulsed %0d times after HLT in %s", extra, row_name[r]);
            errors++;
        end
        assert (got.size() == exp_count[r]) else begin
            $display("** Error at %0t: %s expected %0d outputs, got %0d",
                     $time, row_name[r], exp_count[r], got.size());
            errors++;
        end
        n = (got.size() < exp_count[r]) ? got.size() : exp_count[r];
        for (i = 0; i < n; i++) begin
            assert (got[i] == exp_val[r][i]) else begin
                $display("** Error at %0t: %s output %0d expected 0x%02h, got 0x%02h",
                         $time, row_name[r], i, exp_val[r][i], got[i]);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        run = 1'b0;
        @(negedge clk);
        @(negedge clk);                                 // one edge with run low
        assert (!halted) else begin
            $display("halted still high after run went low in %s", row_name[r]);
            errors++;
        end
        if (errors == 0) begin
            pass_count++;
            $display("test %s passed with %0d outputs", row_name[r], got.size());
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", row_name[r], errors);
        end
    endtask

    initial begin
        int r;
        rst_n      = 1'b0;
        run        = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(32'h631b_e279));                 // single seed for the run
        fill_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && !halted) else begin
            $display("out_valid or halted was high right after reset");
            fail_count++;
        end
        for (r = 0; r < NUM_ROWS; r++) begin
            execute_row(r);
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
sap_data_pkg.sv
sap_ctrl_pkg.sv
alu.sv
program_counter.sv
memory_unit.sv
register_block.sv
sequencer.sv
sap_cpu.sv
tb_sap_cpu.sv

// ==== Bender.yml ====
package:
  name: sap_cpu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sap_data_pkg.sv
      - sap_ctrl_pkg.sv
      - alu.sv
      - program_counter.sv
      - memory_unit.sv
      - register_block.sv
      - sequencer.sv
      - sap_cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sap_cpu.sv
